// File: hdl/issue_pkg.sv
//######################################################################
// shared widths, opcodes and the instruction word of the issue stage
// ID 0 is reserved as "none", usable commit IDs are 1..NUM_SLOTS-1
//######################################################################
package issue_pkg;

    localparam int REG_ADDR_W = 3;   // x0..x7
    localparam int DATA_W     = 16;
    localparam int ID_W       = 3;
    localparam int NUM_SLOTS  = 8;   // slot 0 never allocated
    localparam int NUM_LANES  = 4;
    localparam int MUL_CYCLES = 16;  // one iteration per operand bit

    typedef enum logic {
        OP_ADDI = 1'b0,  // rd = rs1 + imm
        OP_MUL  = 1'b1   // rd = low half of rs1 * rs2
    } op_e;

    // one decoded instruction as it arrives from the source
    typedef struct packed {
        logic                  valid;
        op_e                   op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;  // only read by MUL
        logic [DATA_W-1:0]     imm;  // only read by ADDI
    } inst_t;

endpackage

// File: hdl/lane_if.sv
//######################################################################
// dispatch and writeback bundles of one execution lane
// start only while busy is low, done holds its data until grant
//######################################################################
`timescale 1ns/100ps

interface dispatch_if;
    import issue_pkg::*;

    logic                  start;  // single-cycle pulse
    op_e                   op;
    logic [DATA_W-1:0]     opa;    // rs1 value
    logic [DATA_W-1:0]     opb;    // rs2 value or immediate
    logic [REG_ADDR_W-1:0] rd;
    logic [ID_W-1:0]       id;
    logic                  busy;   // high from start until grant

    modport issuer (output start, op, opa, opb, rd, id, input busy);
    modport lane   (input start, op, opa, opb, rd, id, output busy);
endinterface

interface wb_if;
    import issue_pkg::*;

    logic                  done;
    logic [REG_ADDR_W-1:0] rd;
    logic [ID_W-1:0]       id;
    logic [DATA_W-1:0]     result;
    logic                  grant;  // pulse, done drops on the next edge

    modport producer (output done, rd, id, result, input grant);
    modport drain    (input done, rd, id, result, output grant);
endinterface

// File: hdl/hazard_unit.sv
//######################################################################
// scoreboard of in-flight destinations, RAW/WAW check, ID allocation
// B never issues without A; an x0 destination takes no ID and no lane
// an entry freed in the current cycle no longer counts as a hazard
//######################################################################
`timescale 1ns/100ps

module hazard_unit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  issue_pkg::inst_t              inst_a_i,
    input  issue_pkg::inst_t              inst_b_i,
    input  logic [2:0]                    lane_free_cnt_i,
    input  logic                          wb_we_i,
    input  logic [issue_pkg::ID_W-1:0]    wb_id_i,
    output logic [1:0]                    issue_o,   // bit0 A, bit1 B
    output logic [issue_pkg::ID_W-1:0]    id_a_o,    // 0 when nothing allocated
    output logic [issue_pkg::ID_W-1:0]    id_b_o,
    output logic                          sb_busy_o
);
    import issue_pkg::*;

    logic [NUM_SLOTS-1:0]  sb_valid;
    logic [REG_ADDR_W-1:0] sb_rd [NUM_SLOTS];
    logic [NUM_SLOTS-1:0]  live;        // valid minus the slot freed now
    logic                  haz_a, haz_b;
    logic                  dep_ab;      // B reads or rewrites A's rd
    logic                  need_a, need_b;
    logic                  ids_ok;
    logic [ID_W:0]         free_cnt;
    logic [ID_W-1:0]       first_id, second_id;
    logic                  rd_clash;    // two live entries share an rd

    // true when instruction i reads register r (x0 never counts)
    function automatic logic reads_reg(inst_t i, logic [REG_ADDR_W-1:0] r);
        return (r != '0) && ((i.rs1 == r) || ((i.op == OP_MUL) && (i.rs2 == r)));
    endfunction

    always_comb begin
        live = sb_valid;
        if (wb_we_i) live[wb_id_i] = 1'b0;  // result bypassed by the reg file
        haz_a     = 1'b0;
        haz_b     = 1'b0;
        free_cnt  = '0;
        first_id  = '0;
        second_id = '0;
        for (int i = 1; i < NUM_SLOTS; i++) begin
            if (live[i]) begin
                // sb_rd is never x0, so rd match is a real WAW
                haz_a |= reads_reg(inst_a_i, sb_rd[i]) || (inst_a_i.rd == sb_rd[i]);
                haz_b |= reads_reg(inst_b_i, sb_rd[i]) || (inst_b_i.rd == sb_rd[i]);
            end
            if (!sb_valid[i]) begin
                free_cnt = free_cnt + 1'b1;
                if (first_id == '0)       first_id  = ID_W'(i);  // lowest free
                else if (second_id == '0) second_id = ID_W'(i);  // next one up
            end
        end
    end

    assign need_a = inst_a_i.valid && (inst_a_i.rd != '0);
    assign need_b = inst_b_i.valid && (inst_b_i.rd != '0);
    assign ids_ok = free_cnt >= 2;  // room for a full pair
    assign dep_ab = reads_reg(inst_b_i, inst_a_i.rd)
                 || ((inst_a_i.rd != '0) && (inst_a_i.rd == inst_b_i.rd));

    // x0 destinations issue at once, their result is dropped
    assign issue_o[0] = inst_a_i.valid
                     && (!need_a || (!haz_a && ids_ok && lane_free_cnt_i >= 3'd1));
    assign issue_o[1] = issue_o[0] && inst_b_i.valid
                     && (!need_b || (!haz_b && !dep_ab && ids_ok
                                     && lane_free_cnt_i >= (need_a ? 3'd2 : 3'd1)));

    assign id_a_o = (issue_o[0] && need_a) ? first_id : '0;
    assign id_b_o = (issue_o[1] && need_b) ? (need_a ? second_id : first_id) : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sb_valid <= '0;
        end else begin
            if (wb_we_i && wb_id_i != '0) sb_valid[wb_id_i] <= 1'b0;
            if (id_a_o != '0) sb_valid[id_a_o] <= 1'b1;  // never the slot being freed
            if (id_b_o != '0) sb_valid[id_b_o] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (id_a_o != '0) sb_rd[id_a_o] <= inst_a_i.rd;
        if (id_b_o != '0) sb_rd[id_b_o] <= inst_b_i.rd;
    end

    assign sb_busy_o = |sb_valid;

    // pairwise search over the live entries
    always_comb begin
        rd_clash = 1'b0;
        for (int i = 1; i < NUM_SLOTS; i++) begin
            for (int j = i + 1; j < NUM_SLOTS; j++) begin
                if (sb_valid[i] && sb_valid[j] && (sb_rd[i] == sb_rd[j])) rd_clash = 1'b1;
            end
        end
    end

    // WAW stall keeps one live entry per destination
    a_live_rd_unique: assert property (@(posedge clk) disable iff (!rst_n)
        !rd_clash);

    // writeback only ever returns a nonzero ID that is still live
    a_free_live_id: assert property (@(posedge clk) disable iff (!rst_n)
        wb_we_i |-> ((wb_id_i != '0) && sb_valid[wb_id_i]));

endmodule

// File: hdl/issue_stage.sv
//######################################################################
// four-phase pair intake, operand read and lane dispatch
// holds one pair at a time, B moves into slot A after a partial issue
//######################################################################
`timescale 1ns/100ps

module issue_stage (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             pair_req_i,
    input  issue_pkg::inst_t                 inst_a_i,
    input  issue_pkg::inst_t                 inst_b_i,
    output logic                             pair_ack_o,
    input  logic [1:0]                       issue_i,
    input  logic [issue_pkg::ID_W-1:0]       id_a_i,
    input  logic [issue_pkg::ID_W-1:0]       id_b_i,
    output logic [issue_pkg::REG_ADDR_W-1:0] raddr_o [4],
    input  logic [issue_pkg::DATA_W-1:0]     rdata_i [4],
    dispatch_if.issuer                       lanes [issue_pkg::NUM_LANES],
    output issue_pkg::inst_t                 inst_a_o,
    output issue_pkg::inst_t                 inst_b_o,
    output logic [2:0]                       lane_free_cnt_o
);
    import issue_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_HOLD, S_ACK} state_e;

    state_e                     state;
    inst_t                      slot_a, slot_b;
    logic [NUM_LANES-1:0]       lane_busy, lane_free, start_r;
    logic [$clog2(NUM_LANES)-1:0] lane_a, lane_b;
    logic                       got_a, got_b;
    logic                       go_a, go_b;
    op_e                        op_r  [NUM_LANES];
    logic [DATA_W-1:0]          opa_r [NUM_LANES];
    logic [DATA_W-1:0]          opb_r [NUM_LANES];
    logic [REG_ADDR_W-1:0]      rd_r  [NUM_LANES];
    logic [ID_W-1:0]            id_r  [NUM_LANES];

    // nothing presented outside HOLD, so nothing can issue there
    assign inst_a_o   = (state == S_HOLD) ? slot_a : '0;
    assign inst_b_o   = (state == S_HOLD) ? slot_b : '0;
    assign pair_ack_o = (state == S_ACK);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= S_IDLE;
            slot_a <= '0;
            slot_b <= '0;
        end else begin
            case (state)
                S_IDLE: if (pair_req_i) begin
                    state  <= S_HOLD;
                    slot_a <= inst_a_i.valid ? inst_a_i : inst_b_i;  // compact a lone B
                    slot_b <= inst_a_i.valid ? inst_b_i : '0;
                end
                S_HOLD: begin
                    if (!slot_a.valid || (issue_i[0] && (issue_i[1] || !slot_b.valid))) begin
                        state <= S_ACK;  // last one went out this cycle
                    end else if (issue_i[0]) begin
                        slot_a <= slot_b;
                        slot_b <= '0;
                    end
                end
                default: if (!pair_req_i) state <= S_IDLE;  // ack drops next cycle
            endcase
        end
    end

    // a lane with start in flight is not free yet, busy lags by one edge
    assign lane_free = ~lane_busy & ~start_r;

    always_comb begin
        lane_a = '0;
        lane_b = '0;
        got_a  = 1'b0;
        got_b  = 1'b0;
        lane_free_cnt_o = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (lane_free[i]) begin
                lane_free_cnt_o = lane_free_cnt_o + 1'b1;
                if (!got_a) begin
                    lane_a = i[$clog2(NUM_LANES)-1:0];
                    got_a  = 1'b1;
                end else if (!got_b) begin
                    lane_b = i[$clog2(NUM_LANES)-1:0];
                    got_b  = 1'b1;
                end
            end
        end
    end

    assign go_a = issue_i[0] && (inst_a_o.rd != '0);
    assign go_b = issue_i[1] && (inst_b_o.rd != '0);

    // A reads ports 0/1, B reads ports 2/3
    assign raddr_o[0] = inst_a_o.rs1;
    assign raddr_o[1] = inst_a_o.rs2;
    assign raddr_o[2] = inst_b_o.rs1;
    assign raddr_o[3] = inst_b_o.rs2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_r <= '0;
        end else begin
            start_r <= '0;
            if (go_a) start_r[lane_a] <= 1'b1;
            if (go_b) start_r[go_a ? lane_b : lane_a] <= 1'b1;  // x0 A leaves lane_a
        end
    end

    always_ff @(posedge clk) begin
        if (go_a) begin
            op_r[lane_a]  <= inst_a_o.op;
            opa_r[lane_a] <= rdata_i[0];
            opb_r[lane_a] <= (inst_a_o.op == OP_MUL) ? rdata_i[1] : inst_a_o.imm;
            rd_r[lane_a]  <= inst_a_o.rd;
            id_r[lane_a]  <= id_a_i;
        end
        if (go_b) begin
            op_r[go_a ? lane_b : lane_a]  <= inst_b_o.op;
            opa_r[go_a ? lane_b : lane_a] <= rdata_i[2];
            opb_r[go_a ? lane_b : lane_a] <= (inst_b_o.op == OP_MUL) ? rdata_i[3] : inst_b_o.imm;
            rd_r[go_a ? lane_b : lane_a]  <= inst_b_o.rd;
            id_r[go_a ? lane_b : lane_a]  <= id_b_i;
        end
    end

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign lane_busy[g]   = lanes[g].busy;
        assign lanes[g].start = start_r[g];
        assign lanes[g].op    = op_r[g];
        assign lanes[g].opa   = opa_r[g];
        assign lanes[g].opb   = opb_r[g];
        assign lanes[g].rd    = rd_r[g];
        assign lanes[g].id    = id_r[g];

        // lane must have finished its last writeback before a new start
        a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
            start_r[g] |-> !lane_busy[g]);
    end

endmodule

// File: hdl/reg_file.sv
//######################################################################
// 8x16 register file, four async reads, one write
// x0 reads zero, a same-cycle write is bypassed to the readers
//######################################################################
`timescale 1ns/100ps

module reg_file (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [issue_pkg::REG_ADDR_W-1:0] raddr_i [4],
    output logic [issue_pkg::DATA_W-1:0]     rdata_o [4],
    input  logic                             we_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [issue_pkg::DATA_W-1:0]     wdata_i
);
    import issue_pkg::*;

    logic [DATA_W-1:0] regs [2**REG_ADDR_W];  // regs[0] stays zero

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) regs[i] <= '0;  // architectural zero state
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            if (raddr_i[p] == '0)                     rdata_o[p] = '0;
            else if (we_i && (waddr_i == raddr_i[p])) rdata_o[p] = wdata_i;  // bypass
            else                                      rdata_o[p] = regs[raddr_i[p]];
        end
    end

endmodule

// File: hdl/exec_lane.sv
//######################################################################
// one execution lane, ADDI in 1 cycle, MUL by 16-step shift-add
// result, rd and id are held until the writeback grant
//######################################################################
`timescale 1ns/100ps

module exec_lane (
    input  logic      clk,
    input  logic      rst_n,
    dispatch_if.lane  disp,
    wb_if.producer    wb
);
    import issue_pkg::*;

    logic                          busy_r, run_r, done_r;
    logic [$clog2(MUL_CYCLES)-1:0] cnt_r;     // remaining iterations
    logic [DATA_W-1:0]             acc;       // product so far, or the sum
    logic [DATA_W-1:0]             mcand;     // shifted rs1
    logic [DATA_W-1:0]             mplier;    // rs2, consumed lsb first
    logic [DATA_W-1:0]             part;
    logic [REG_ADDR_W-1:0]         rd_r;
    logic [ID_W-1:0]               id_r;

    assign part = mplier[0] ? mcand : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_r <= 1'b0;
            run_r  <= 1'b0;
            done_r <= 1'b0;
            cnt_r  <= '0;
        end else if (disp.start) begin
            busy_r <= 1'b1;
            run_r  <= (disp.op == OP_MUL);
            done_r <= (disp.op == OP_ADDI);       // add finishes on this edge
            cnt_r  <= $bits(cnt_r)'(MUL_CYCLES - 2);  // bit 0 done at load
        end else if (run_r) begin
            cnt_r <= cnt_r - 1'b1;
            if (cnt_r == '0) begin
                run_r  <= 1'b0;
                done_r <= 1'b1;                   // MUL_CYCLES after start
            end
        end else if (wb.grant) begin
            done_r <= 1'b0;
            busy_r <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (disp.start) begin
            rd_r   <= disp.rd;
            id_r   <= disp.id;
            mcand  <= disp.opa << 1;
            mplier <= disp.opb >> 1;
            if (disp.op == OP_MUL) acc <= disp.opb[0] ? disp.opa : '0;
            else                   acc <= disp.opa + disp.opb;  // wraps at 16 bits
        end else if (run_r) begin
            acc    <= acc + part;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign disp.busy = busy_r;
    assign wb.done   = done_r;
    assign wb.rd     = rd_r;
    assign wb.id     = id_r;
    assign wb.result = acc;

endmodule

// File: hdl/wb_arbiter.sv
//######################################################################
// fixed priority drain of finished lanes, lane 0 wins
// one registered writeback per cycle, no back-pressure
//######################################################################
`timescale 1ns/100ps

module wb_arbiter (
    input  logic                             clk,
    input  logic                             rst_n,
    wb_if.drain                              lanes [issue_pkg::NUM_LANES],
    output logic                             wb_we_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [issue_pkg::ID_W-1:0]       wb_id_o,
    output logic [issue_pkg::DATA_W-1:0]     wb_data_o
);
    import issue_pkg::*;

    logic [NUM_LANES-1:0]  done, grant;
    logic [REG_ADDR_W-1:0] rd     [NUM_LANES];
    logic [ID_W-1:0]       id     [NUM_LANES];
    logic [DATA_W-1:0]     result [NUM_LANES];

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign done[g]        = lanes[g].done;
        assign rd[g]          = lanes[g].rd;
        assign id[g]          = lanes[g].id;
        assign result[g]      = lanes[g].result;
        assign lanes[g].grant = grant[g];

        // a waiting lane keeps done and its data until granted
        a_done_held: assert property (@(posedge clk) disable iff (!rst_n)
            (done[g] && !grant[g]) |=>
                (done[g] && $stable(result[g]) && $stable(rd[g]) && $stable(id[g])));

        // done falls on the edge after the grant
        a_done_drops: assert property (@(posedge clk) disable iff (!rst_n)
            grant[g] |=> !done[g]);
    end

    assign grant = done & (~done + 1'b1);  // isolate lowest set bit

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) wb_we_o <= 1'b0;
        else        wb_we_o <= |done;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (grant[i]) begin
                wb_rd_o   <= rd[i];
                wb_id_o   <= id[i];
                wb_data_o <= result[i];
            end
        end
    end

endmodule

// File: hdl/core_issue_top.sv
//######################################################################
// dual-issue in-order issue stage with four execution lanes
// pair_req_i/pair_ack_o are four-phase, writeback never stalls
//######################################################################
`timescale 1ns/100ps

module core_issue_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             pair_req_i,
    output logic                             pair_ack_o,
    input  issue_pkg::op_e                   a_op_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] a_rd_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] a_rs1_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] a_rs2_i,
    input  logic [issue_pkg::DATA_W-1:0]     a_imm_i,
    input  logic                             a_valid_i,
    input  issue_pkg::op_e                   b_op_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] b_rd_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] b_rs1_i,
    input  logic [issue_pkg::REG_ADDR_W-1:0] b_rs2_i,
    input  logic [issue_pkg::DATA_W-1:0]     b_imm_i,
    input  logic                             b_valid_i,
    output logic                             wb_valid_o,
    output logic [issue_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [issue_pkg::DATA_W-1:0]     wb_data_o,
    output logic                             sb_busy_o
);
    import issue_pkg::*;

    inst_t                 inst_a, inst_b;  // from the ports
    inst_t                 hz_a, hz_b;      // what the hazard unit sees
    logic [1:0]            issue;
    logic [ID_W-1:0]       id_a, id_b, wb_id;
    logic [2:0]            lane_free_cnt;
    logic [REG_ADDR_W-1:0] raddr [4];
    logic [DATA_W-1:0]     rdata [4];
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [DATA_W-1:0]     wb_data;

    dispatch_if disp [NUM_LANES] ();
    wb_if       wbl  [NUM_LANES] ();

    assign inst_a = '{valid: a_valid_i, op: a_op_i, rd: a_rd_i,
                      rs1: a_rs1_i, rs2: a_rs2_i, imm: a_imm_i};
    assign inst_b = '{valid: b_valid_i, op: b_op_i, rd: b_rd_i,
                      rs1: b_rs1_i, rs2: b_rs2_i, imm: b_imm_i};

    assign wb_valid_o = wb_we;
    assign wb_rd_o    = wb_rd;
    assign wb_data_o  = wb_data;

    issue_stage u_issue (
        .clk, .rst_n, .pair_req_i, .inst_a_i(inst_a), .inst_b_i(inst_b), .pair_ack_o,
        .issue_i(issue), .id_a_i(id_a), .id_b_i(id_b), .raddr_o(raddr), .rdata_i(rdata),
        .lanes(disp), .inst_a_o(hz_a), .inst_b_o(hz_b), .lane_free_cnt_o(lane_free_cnt)
    );

    hazard_unit u_hazard (
        .clk, .rst_n, .inst_a_i(hz_a), .inst_b_i(hz_b), .lane_free_cnt_i(lane_free_cnt),
        .wb_we_i(wb_we), .wb_id_i(wb_id), .issue_o(issue), .id_a_o(id_a), .id_b_o(id_b),
        .sb_busy_o
    );

    reg_file u_rf (
        .clk, .rst_n, .raddr_i(raddr), .rdata_o(rdata),
        .we_i(wb_we), .waddr_i(wb_rd), .wdata_i(wb_data)
    );

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        exec_lane u_lane (.clk, .rst_n, .disp(disp[g]), .wb(wbl[g]));
    end

    wb_arbiter u_arb (
        .clk, .rst_n, .lanes(wbl),
        .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_id_o(wb_id), .wb_data_o(wb_data)
    );

endmodule

// File: tests/tb_core_issue.sv
//######################################################################
// drives 300 LCG pairs into core_issue_top, checks against a sequential model
// pairs 0..99 ADDI only, 100..199 MUL only, 200..299 mixed
// stops at the first mismatch, cycle limit sized for all-MUL chains
//######################################################################
`timescale 1ns/100ps

module tb_core_issue;
    import issue_pkg::*;

    localparam int NUM_PAIRS      = 300;
    localparam int TIMEOUT_CYCLES = NUM_PAIRS * 2 * (MUL_CYCLES + 8);

    logic                  clk;
    logic                  rst_n;
    logic                  pair_req;
    logic                  pair_ack;
    op_e                   a_op, b_op;
    logic [REG_ADDR_W-1:0] a_rd, a_rs1, a_rs2;
    logic [REG_ADDR_W-1:0] b_rd, b_rs1, b_rs2;
    logic [DATA_W-1:0]     a_imm, b_imm;
    logic                  a_valid, b_valid;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [DATA_W-1:0]     wb_data;
    logic                  sb_busy;

    logic [31:0]           seed;                          // LCG state
    logic [DATA_W-1:0]     model_rf [2**REG_ADDR_W];      // architectural view
    logic [DATA_W-1:0]     exp_q    [2**REG_ADDR_W][$];   // results in program order
    int                    exp_count;                     // non-x0 instructions sent
    int                    wb_count;
    int                    cycle_cnt = 0;

    core_issue_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .pair_req_i (pair_req),
        .pair_ack_o (pair_ack),
        .a_op_i     (a_op),
        .a_rd_i     (a_rd),
        .a_rs1_i    (a_rs1),
        .a_rs2_i    (a_rs2),
        .a_imm_i    (a_imm),
        .a_valid_i  (a_valid),
        .b_op_i     (b_op),
        .b_rd_i     (b_rd),
        .b_rs1_i    (b_rs1),
        .b_rs2_i    (b_rs2),
        .b_imm_i    (b_imm),
        .b_valid_i  (b_valid),
        .wb_valid_o (wb_valid),
        .wb_rd_o    (wb_rd),
        .wb_data_o  (wb_data),
        .sb_busy_o  (sb_busy)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected value of one instruction from its source values
    function automatic logic [DATA_W-1:0] ref_result(input op_e op,
            input logic [DATA_W-1:0] src1, input logic [DATA_W-1:0] src2,
            input logic [DATA_W-1:0] imm);
        logic [2*DATA_W-1:0] prod;
        prod = src1 * src2;
        if (op == OP_MUL) return prod[DATA_W-1:0];  // low half only
        return src1 + imm;                           // wraps at 16 bits
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected)
            stop_with_failure($sformatf("ERROR at %0d ns: %s got 0x%0h expected 0x%0h",
                                        $time, name, got, expected));
    endtask

    task automatic draw(output logic [31:0] r);
        seed = lcg_next(seed);
        r    = seed;
    endtask

    // run one instruction on the model, x0 results are never written back
    task automatic model_step(input logic valid, input op_e op,
            input logic [REG_ADDR_W-1:0] rd, input logic [REG_ADDR_W-1:0] rs1,
            input logic [REG_ADDR_W-1:0] rs2, input logic [DATA_W-1:0] imm);
        logic [DATA_W-1:0] res;
        if (valid && rd != '0) begin
            res          = ref_result(op, model_rf[rs1], model_rf[rs2], imm);
            model_rf[rd] = res;
            exp_q[rd].push_back(res);
            exp_count    = exp_count + 1;
        end
    endtask

    // mode 0 ADDI, 1 MUL, 2 mixed
    task automatic send_pair(input int mode);
        logic [31:0] ra, rb;
        op_e         opa, opb;
        logic        va, vb;
        draw(ra);
        draw(rb);
        opa = (mode == 2) ? op_e'(ra[22]) : op_e'(mode[0]);
        opb = (mode == 2) ? op_e'(rb[22]) : op_e'(mode[0]);
        va  = (ra[21:19] != 3'd0);  // A missing 1 in 8
        vb  = (rb[21:20] != 2'd0);  // B missing 1 in 4
        @(posedge clk);
        a_valid  <= va;
        a_op     <= opa;
        a_rd     <= ra[31:29];
        a_rs1    <= ra[28:26];
        a_rs2    <= ra[25:23];
        a_imm    <= ra[15:0];
        b_valid  <= vb;
        b_op     <= opb;
        b_rd     <= rb[31:29];
        b_rs1    <= rb[28:26];
        b_rs2    <= rb[25:23];
        b_imm    <= rb[15:0];
        pair_req <= 1'b1;
        // program order is A then B
        model_step(va, opa, ra[31:29], ra[28:26], ra[25:23], ra[15:0]);
        model_step(vb, opb, rb[31:29], rb[28:26], rb[25:23], rb[15:0]);
        do @(negedge clk); while (!pair_ack);
        @(posedge clk);
        pair_req <= 1'b0;
        do @(negedge clk); while (pair_ack);  // four-phase closed
    endtask

    // compare every writeback with the oldest result for its register
    always @(negedge clk) begin
        if (rst_n && wb_valid) begin
            wb_count = wb_count + 1;
            if (wb_rd == '0)
                stop_with_failure("writeback to x0 seen, x0 results must be dropped");
            else if (exp_q[wb_rd].size() == 0)
                stop_with_failure($sformatf("writeback to x%0d with no result outstanding",
                                            wb_rd));
            else
                check_value("wb_data_o", wb_data, exp_q[wb_rd].pop_front());
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            stop_with_failure($sformatf("timeout, run did not finish within %0d cycles",
                                        TIMEOUT_CYCLES));
    end

    initial begin
        seed      = 32'h5746_5cda;
        rst_n     = 1'b0;
        pair_req  = 1'b0;
        a_valid   = 1'b0;
        a_op      = OP_ADDI;
        a_rd      = '0;
        a_rs1     = '0;
        a_rs2     = '0;
        a_imm     = '0;
        b_valid   = 1'b0;
        b_op      = OP_ADDI;
        b_rd      = '0;
        b_rs1     = '0;
        b_rs2     = '0;
        b_imm     = '0;
        exp_count = 0;
        wb_count  = 0;
        foreach (model_rf[i]) model_rf[i] = '0;  // rf resets to zero
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("pair_ack_o", pair_ack, 0);
        check_value("wb_valid_o", wb_valid, 0);
        check_value("sb_busy_o", sb_busy, 0);
        for (int p = 0; p < NUM_PAIRS; p++) send_pair(p / (NUM_PAIRS / 3));
        // drain, timeout covers a stuck scoreboard
        while (sb_busy) @(negedge clk);
        if (wb_count != exp_count)
            stop_with_failure($sformatf("ERROR at %0d ns: wb_count got %0d expected %0d",
                                        $time, wb_count, exp_count));
        else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// File: vlog.f
hdl/issue_pkg.sv
hdl/lane_if.sv
hdl/hazard_unit.sv
hdl/issue_stage.sv
hdl/reg_file.sv
hdl/exec_lane.sv
hdl/wb_arbiter.sv
hdl/core_issue_top.sv
tests/tb_core_issue.sv

// File: Makefile
# Verilator simulation of core_issue_top with tb_core_issue
TOP := tb_core_issue
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  make test   build with Verilator, run, fail if the log reports failure"
	@echo "  make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f vlog.f -Mdir $(OBJ) -o V$(TOP)
	./$(OBJ)/V$(TOP) | tee sim.log
	@if grep -q "Result: FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Result: PASSED" sim.log; then echo "no result in log"; exit 1; fi

clean:
	rm -rf $(OBJ) sim.log
